// File: dv/l2_localmem_tb.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_localmem_tb import l2_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 4;
    localparam int INIT_OPS = `L2_SETS * `L2_WAYS;
    localparam int DIRECTED_OPS = 24;
    localparam int RANDOM_OPS = 400;
    localparam int TOTAL_OPS = INIT_OPS + DIRECTED_OPS + RANDOM_OPS;
    localparam int WATCHDOG_NS = 2 * TOTAL_OPS * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic       clk;
    logic       wr_rst;
    logic       rd_en;
    l2_set_t    set_in;
    l2_way_t    way;
    line_t      wr_data_line;
    l2_tag_t    wr_data_tag;
    state_t     wr_data_state;
    hprot_t     wr_data_hprot;
    l2_way_t    wr_data_evict_way;
    logic       wr_en_line;
    logic       wr_en_tag;
    logic       wr_en_state;
    logic       wr_en_hprot;
    logic       wr_en_evict_way;
    logic       wr_state_all;
    line_vec_t  rd_data_line;
    tag_vec_t   rd_data_tag;
    state_vec_t rd_data_state;
    hprot_vec_t rd_data_hprot;
    l2_way_t    rd_data_evict_way;

    // reference storage
    line_t   m_line [`L2_SETS][`L2_WAYS];
    l2_tag_t m_tag [`L2_SETS][`L2_WAYS];
    state_t  m_state [`L2_SETS][`L2_WAYS];
    hprot_t  m_hprot [`L2_SETS][`L2_WAYS];
    l2_way_t m_evict [`L2_SETS];

    // what the outputs should show after the last rising edge
    line_vec_t  exp_line;
    tag_vec_t   exp_tag;
    state_vec_t exp_state;
    hprot_vec_t exp_hprot;
    l2_way_t    exp_evict;

    logic check_en;
    int   errors;
    int   n_ops;
    int   n_reads;

    l2_localmem UUT (
        .clk               (clk),
        .wr_rst            (wr_rst),
        .rd_en             (rd_en),
        .set_in            (set_in),
        .way               (way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_state     (wr_data_state),
        .wr_data_hprot     (wr_data_hprot),
        .wr_data_evict_way (wr_data_evict_way),
        .wr_en_line        (wr_en_line),
        .wr_en_tag         (wr_en_tag),
        .wr_en_state       (wr_en_state),
        .wr_en_hprot       (wr_en_hprot),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_state_all      (wr_state_all),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_state     (rd_data_state),
        .rd_data_hprot     (rd_data_hprot),
        .rd_data_evict_way (rd_data_evict_way)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    line_check: assert property (@(posedge clk) disable iff (!check_en)
        rd_data_line === exp_line)
    else begin
        errors++;
        $display("FAILED t=%0t rd_data_line expected %h actual %h",
            $time, $sampled(exp_line), $sampled(rd_data_line));
    end

    tag_check: assert property (@(posedge clk) disable iff (!check_en)
        rd_data_tag === exp_tag)
    else begin
        errors++;
        $display("FAILED t=%0t rd_data_tag expected %h actual %h",
            $time, $sampled(exp_tag), $sampled(rd_data_tag));
    end

    state_check: assert property (@(posedge clk) disable iff (!check_en)
        rd_data_state === exp_state)
    else begin
        errors++;
        $display("FAILED t=%0t rd_data_state expected %h actual %h",
            $time, $sampled(exp_state), $sampled(rd_data_state));
    end

    hprot_check: assert property (@(posedge clk) disable iff (!check_en)
        rd_data_hprot === exp_hprot)
    else begin
        errors++;
        $display("FAILED t=%0t rd_data_hprot expected %h actual %h",
            $time, $sampled(exp_hprot), $sampled(rd_data_hprot));
    end

    evict_check: assert property (@(posedge clk) disable iff (!check_en)
        rd_data_evict_way === exp_evict)
    else begin
        errors++;
        $display("FAILED t=%0t rd_data_evict_way expected %h actual %h",
            $time, $sampled(exp_evict), $sampled(rd_data_evict_way));
    end

    // no read strobe at the last edge, so nothing on the outputs may move
    hold_check: assert property (@(posedge clk) disable iff (!check_en)
        (!$past(rd_en) && !$past(wr_rst)) |->
        $stable({rd_data_line, rd_data_tag, rd_data_state, rd_data_hprot, rd_data_evict_way}))
    else begin
        errors++;
        $display("FAILED t=%0t rd_data outputs changed while rd_en was low", $time);
    end

    // applies the rising edge that just passed to the model, read before write
    task automatic commit_cycle();
        if (wr_rst) begin
            exp_line = '0;
            exp_tag = '0;
            exp_state = '0;
            exp_hprot = '0;
            exp_evict = '0;
        end else if (rd_en) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                exp_line[w] = m_line[set_in][w];
                exp_tag[w] = m_tag[set_in][w];
                exp_state[w] = m_state[set_in][w];
                exp_hprot[w] = m_hprot[set_in][w];
            end
            exp_evict = m_evict[set_in];
            n_reads++;
        end

        if (wr_en_line) begin
            m_line[set_in][way] = wr_data_line;
        end
        if (wr_en_tag) begin
            m_tag[set_in][way] = wr_data_tag;
        end
        if (wr_en_hprot) begin
            m_hprot[set_in][way] = wr_data_hprot;
        end
        if (wr_state_all) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                m_state[set_in][w] = wr_data_state;
            end
        end else if (wr_en_state) begin
            m_state[set_in][way] = wr_data_state;
        end
        if (wr_en_evict_way) begin
            m_evict[set_in] = wr_data_evict_way;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        commit_cycle();
        rd_en = 1'b0;
        wr_en_line = 1'b0;
        wr_en_tag = 1'b0;
        wr_en_state = 1'b0;
        wr_en_hprot = 1'b0;
        wr_en_evict_way = 1'b0;
        wr_state_all = 1'b0;
        n_ops++;
    endtask

    task automatic random_data();
        wr_data_line = {$urandom, $urandom, $urandom, $urandom};
        wr_data_tag = l2_tag_t'($urandom);
        wr_data_state = state_t'($urandom);
        wr_data_hprot = hprot_t'($urandom);
        wr_data_evict_way = l2_way_t'($urandom);
    endtask

    task automatic write_way(input l2_set_t s, input l2_way_t w, input logic en_line,
                             input logic en_tag, input logic en_state, input logic en_hprot);
        next_cycle();
        random_data();
        set_in = s;
        way = w;
        wr_en_line = en_line;
        wr_en_tag = en_tag;
        wr_en_state = en_state;
        wr_en_hprot = en_hprot;
    endtask

    task automatic broadcast_state(input l2_set_t s, input state_t st);
        next_cycle();
        random_data();
        set_in = s;
        way = l2_way_t'($urandom);
        wr_data_state = st;
        wr_en_state = ($urandom_range(1) == 1);
        wr_state_all = 1'b1;
    endtask

    task automatic write_evict(input l2_set_t s, input l2_way_t w, input l2_way_t ev);
        next_cycle();
        random_data();
        set_in = s;
        way = w;
        wr_data_evict_way = ev;
        wr_en_evict_way = 1'b1;
    endtask

    task automatic read_set(input l2_set_t s);
        next_cycle();
        set_in = s;
        way = l2_way_t'($urandom);
        rd_en = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            next_cycle();
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(93319));
        wr_rst = 1'b1;
        rd_en = 1'b0;
        set_in = '0;
        way = '0;
        wr_data_line = '0;
        wr_data_tag = '0;
        wr_data_state = '0;
        wr_data_hprot = '0;
        wr_data_evict_way = '0;
        wr_en_line = 1'b0;
        wr_en_tag = 1'b0;
        wr_en_state = 1'b0;
        wr_en_hprot = 1'b0;
        wr_en_evict_way = 1'b0;
        wr_state_all = 1'b0;
        exp_line = '0;
        exp_tag = '0;
        exp_state = '0;
        exp_hprot = '0;
        exp_evict = '0;
        check_en = 1'b0;
        errors = 0;
        n_ops = 0;
        n_reads = 0;

        repeat (RESET_CYCLES) begin
            next_cycle();
        end
        wr_rst = 1'b0;
        check_en = 1'b1;

        // outputs stay zero until the first read
        idle(3);

        // fill every way of every set so later reads see known data
        for (int s = 0; s < `L2_SETS; s++) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                write_way(l2_set_t'(s), l2_way_t'(w), 1'b1, 1'b1, 1'b1, 1'b1);
                wr_en_evict_way = (w == 0);
            end
        end

        // full write to one way, the others unchanged
        write_way(6'd5, 2'd2, 1'b1, 1'b1, 1'b1, 1'b1);
        read_set(6'd5);

        // tag only
        write_way(6'd5, 2'd1, 1'b0, 1'b1, 1'b0, 1'b0);
        read_set(6'd5);

        broadcast_state(6'd5, 3'b101);
        read_set(6'd5);

        // evict pointer per set
        write_evict(6'd9, 2'd3, 2'd1);
        read_set(6'd9);
        read_set(6'd10);
        read_set(6'd9);

        // read-first on a same cycle write, then hold with rd_en low
        write_way(6'd12, 2'd0, 1'b1, 1'b1, 1'b1, 1'b1);
        rd_en = 1'b1;
        read_set(6'd12);
        write_way(6'd12, 2'd1, 1'b1, 1'b1, 1'b1, 1'b1);
        next_cycle();
        set_in = 6'd13;
        idle(2);

        // narrow set range so reads often hit recent writes
        for (int i = 0; i < RANDOM_OPS; i++) begin
            next_cycle();
            random_data();
            set_in = l2_set_t'($urandom_range(7));
            way = l2_way_t'($urandom);
            rd_en = ($urandom_range(1) == 1);
            wr_en_line = ($urandom_range(3) == 0);
            wr_en_tag = ($urandom_range(3) == 0);
            wr_en_state = ($urandom_range(3) == 0);
            wr_en_hprot = ($urandom_range(3) == 0);
            wr_en_evict_way = ($urandom_range(3) == 0);
            wr_state_all = ($urandom_range(7) == 0);
        end

        idle(2);
        @(posedge clk);
        #1;

        $display("cycles=%0d reads=%0d errors=%0d", n_ops, n_reads, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/l2_localmem.sv
`timescale 1ns/1ps

// L2 local data store: line, tag, state, hprot per way plus evict pointer per set
module l2_localmem import l2_pkg::*; (
    input  logic       clk,
    input  logic       wr_rst,
    input  logic       rd_en,
    input  l2_set_t    set_in,
    input  l2_way_t    way,
    input  line_t      wr_data_line,
    input  l2_tag_t    wr_data_tag,
    input  state_t     wr_data_state,
    input  hprot_t     wr_data_hprot,
    input  l2_way_t    wr_data_evict_way,
    input  logic       wr_en_line,
    input  logic       wr_en_tag,
    input  logic       wr_en_state,
    input  logic       wr_en_hprot,
    input  logic       wr_en_evict_way,
    input  logic       wr_state_all,
    output line_vec_t  rd_data_line,
    output tag_vec_t   rd_data_tag,
    output state_vec_t rd_data_state,
    output hprot_vec_t rd_data_hprot,
    output l2_way_t    rd_data_evict_way
);

    l2_wr_if wr_bus ();
    l2_rd_if rd_bus ();

    l2_wr_decode u_wr_decode (
        .set_in            (set_in),
        .way               (way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_state     (wr_data_state),
        .wr_data_hprot     (wr_data_hprot),
        .wr_data_evict_way (wr_data_evict_way),
        .wr_en_line        (wr_en_line),
        .wr_en_tag         (wr_en_tag),
        .wr_en_state       (wr_en_state),
        .wr_en_hprot       (wr_en_hprot),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_state_all      (wr_state_all),
        .wr                (wr_bus.src)
    );

    l2_way_store u_way_store (
        .clk (clk),
        .wr  (wr_bus.dst),
        .rd  (rd_bus.src)
    );

    l2_rd_stage u_rd_stage (
        .clk               (clk),
        .wr_rst            (wr_rst),
        .rd_en             (rd_en),
        .rd                (rd_bus.dst),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_state     (rd_data_state),
        .rd_data_hprot     (rd_data_hprot),
        .rd_data_evict_way (rd_data_evict_way)
    );

endmodule

// File: hdl/l2_mem_if.sv
`timescale 1ns/1ps

// decoded write request into the storage
interface l2_wr_if import l2_pkg::*; ();

    l2_set_t set;

    line_t line;
    l2_tag_t tag;
    state_t state;
    hprot_t hprot;
    l2_way_t evict_way;

    // per-way enables
    l2_way_en_t line_en;
    l2_way_en_t tag_en;
    l2_way_en_t state_en;
    l2_way_en_t hprot_en;

    // evict pointer is per set, single strobe
    logic evict_en;

    modport src (
        output set, line, tag, state, hprot, evict_way,
        output line_en, tag_en, state_en, hprot_en, evict_en
    );

    modport dst (
        input set, line, tag, state, hprot, evict_way,
        input line_en, tag_en, state_en, hprot_en, evict_en
    );

endinterface

// combinational contents of the addressed set
interface l2_rd_if import l2_pkg::*; ();

    line_vec_t line;
    tag_vec_t tag;
    state_vec_t state;
    hprot_vec_t hprot;
    l2_way_t evict_way;

    modport src (
        output line, tag, state, hprot, evict_way
    );

    modport dst (
        input line, tag, state, hprot, evict_way
    );

endinterface

// File: hdl/l2_pkg.sv
`include "l2_defines.svh"

package l2_pkg;

    // index types
    typedef logic [`L2_SET_BITS-1:0] l2_set_t;
    typedef logic [`L2_WAY_BITS-1:0] l2_way_t;

    // per-way field payloads
    typedef logic [`LINE_BITS-1:0] line_t;
    typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;
    typedef logic [`STATE_BITS-1:0] state_t;
    typedef logic [`HPROT_BITS-1:0] hprot_t;

    // one bit per way
    typedef logic [`L2_WAYS-1:0] l2_way_en_t;

    // one field value for each way of a set, way 0 in the low slot
    typedef line_t [`L2_WAYS-1:0] line_vec_t;
    typedef l2_tag_t [`L2_WAYS-1:0] tag_vec_t;
    typedef state_t [`L2_WAYS-1:0] state_vec_t;
    typedef hprot_t [`L2_WAYS-1:0] hprot_vec_t;

endpackage

// File: hdl/l2_rd_stage.sv
`timescale 1ns/1ps

module l2_rd_stage import l2_pkg::*; (
    input  logic       clk,
    input  logic       wr_rst,
    input  logic       rd_en,
    l2_rd_if.dst       rd,
    output line_vec_t  rd_data_line,
    output tag_vec_t   rd_data_tag,
    output state_vec_t rd_data_state,
    output hprot_vec_t rd_data_hprot,
    output l2_way_t    rd_data_evict_way
);

    // registered read port, holds between reads
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rd_data_line <= '0;
            rd_data_tag <= '0;
            rd_data_state <= '0;
            rd_data_hprot <= '0;
            rd_data_evict_way <= '0;
        end else if (rd_en) begin
            // storage reads are async, this picks up pre-write contents
            rd_data_line <= rd.line;
            rd_data_tag <= rd.tag;
            rd_data_state <= rd.state;
            rd_data_hprot <= rd.hprot;
            rd_data_evict_way <= rd.evict_way;
        end
    end

endmodule

// File: hdl/l2_way_array.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

// one field of one way, one entry per set
module l2_way_array import l2_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  l2_set_t  set,
    input  logic     we,
    input  payload_t wr_data,
    output payload_t rd_data
);

    payload_t mem [0:`L2_SETS-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[set] <= wr_data;
        end
    end

    // async read, so a same-edge capture sees the old entry
    assign rd_data = mem[set];

endmodule

// File: hdl/l2_way_store.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_way_store import l2_pkg::*; (
    input logic  clk,
    l2_wr_if.dst wr,
    l2_rd_if.src rd
);

    line_vec_t line_rd;
    tag_vec_t tag_rd;
    state_vec_t state_rd;
    hprot_vec_t hprot_rd;

    l2_way_t evict_mem [0:`L2_SETS-1];

    genvar w;
    generate
        for (w = 0; w < `L2_WAYS; w++) begin : g_way
            l2_way_array #(
                .payload_t(line_t)
            ) u_line (
                .clk     (clk),
                .set     (wr.set),
                .we      (wr.line_en[w]),
                .wr_data (wr.line),
                .rd_data (line_rd[w])
            );

            l2_way_array #(
                .payload_t(l2_tag_t)
            ) u_tag (
                .clk     (clk),
                .set     (wr.set),
                .we      (wr.tag_en[w]),
                .wr_data (wr.tag),
                .rd_data (tag_rd[w])
            );

            l2_way_array #(
                .payload_t(state_t)
            ) u_state (
                .clk     (clk),
                .set     (wr.set),
                .we      (wr.state_en[w]),
                .wr_data (wr.state),
                .rd_data (state_rd[w])
            );

            l2_way_array #(
                .payload_t(hprot_t)
            ) u_hprot (
                .clk     (clk),
                .set     (wr.set),
                .we      (wr.hprot_en[w]),
                .wr_data (wr.hprot),
                .rd_data (hprot_rd[w])
            );
        end
    endgenerate

    // evict way pointer, shared by all ways of a set
    always_ff @(posedge clk) begin
        if (wr.evict_en) begin
            evict_mem[wr.set] <= wr.evict_way;
        end
    end

    assign rd.line = line_rd;
    assign rd.tag = tag_rd;
    assign rd.state = state_rd;
    assign rd.hprot = hprot_rd;
    assign rd.evict_way = evict_mem[wr.set];

endmodule

// File: hdl/l2_wr_decode.sv
`timescale 1ns/1ps

module l2_wr_decode import l2_pkg::*; (
    input  l2_set_t  set_in,
    input  l2_way_t  way,
    input  line_t    wr_data_line,
    input  l2_tag_t  wr_data_tag,
    input  state_t   wr_data_state,
    input  hprot_t   wr_data_hprot,
    input  l2_way_t  wr_data_evict_way,
    input  logic     wr_en_line,
    input  logic     wr_en_tag,
    input  logic     wr_en_state,
    input  logic     wr_en_hprot,
    input  logic     wr_en_evict_way,
    input  logic     wr_state_all,
    l2_wr_if.src     wr
);

    l2_way_en_t way_oh;

    // one-hot way select
    always_comb begin
        way_oh = '0;
        way_oh[way] = 1'b1;
    end

    // address and payloads go straight through
    assign wr.set = set_in;
    assign wr.line = wr_data_line;
    assign wr.tag = wr_data_tag;
    assign wr.state = wr_data_state;
    assign wr.hprot = wr_data_hprot;
    assign wr.evict_way = wr_data_evict_way;

    always_comb begin
        wr.line_en = wr_en_line ? way_oh : '0;
        wr.tag_en = wr_en_tag ? way_oh : '0;
        wr.hprot_en = wr_en_hprot ? way_oh : '0;

        // broadcast state to every way of the set
        if (wr_state_all) begin
            wr.state_en = '1;
        end else if (wr_en_state) begin
            wr.state_en = way_oh;
        end else begin
            wr.state_en = '0;
        end
    end

    // not way specific
    assign wr.evict_en = wr_en_evict_way;

endmodule

// File: include/l2_defines.svh
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

// associativity
`define L2_WAYS 4
`define L2_WAY_BITS 2

// 64 sets
`define L2_SET_BITS 6
`define L2_SETS 64

// field widths
`define LINE_BITS 128
`define L2_TAG_BITS 20
`define STATE_BITS 3
`define HPROT_BITS 1

`endif

// File: list.f
+incdir+include
hdl/l2_pkg.sv
hdl/l2_mem_if.sv
hdl/l2_wr_decode.sv
hdl/l2_way_array.sv
hdl/l2_way_store.sv
hdl/l2_rd_stage.sv
hdl/l2_localmem.sv
dv/l2_localmem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the L2 local data store testbench with Verilator

verilator --binary --timing --assert -f list.f --top-module l2_localmem_tb \
    -o l2_localmem_tb_sim || { echo "build failed"; exit 1; }

./obj_dir/l2_localmem_tb_sim > sim.log 2>&1 || echo "simulator returned a nonzero status"

grep -q "Result: FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
